/* common/rv_pkg.sv */
package rv_pkg;

    // ------------------------------------------------------------
    // Widths.
    // ------------------------------------------------------------
    localparam int XLEN           = 64;
    localparam int INSTR_WIDTH    = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // ------------------------------------------------------------
    // Opcode field of the supported instructions.
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // ALU operations.
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // ------------------------------------------------------------
    // Multiplexer select codes.
    // ------------------------------------------------------------
    localparam logic [1:0] SRC_A_PC     = 2'd0;
    localparam logic [1:0] SRC_A_OLD_PC = 2'd1;
    localparam logic [1:0] SRC_A_RS1    = 2'd2;

    localparam logic [1:0] SRC_B_RS2    = 2'd0;
    localparam logic [1:0] SRC_B_IMM    = 2'd1;
    localparam logic [1:0] SRC_B_FOUR   = 2'd2;

    // Registered ALU result, memory data, or the live ALU result.
    localparam logic [1:0] RES_ALU_OUT  = 2'd0;
    localparam logic [1:0] RES_MEM_DATA = 2'd1;
    localparam logic [1:0] RES_ALU      = 2'd2;

endpackage

/* decode/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode #(
    parameter int MEM_ADDR_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic [rv_pkg::XLEN - 1:0]           i_mem_rdata,
    input  logic [MEM_ADDR_WIDTH - 1:0]         i_pc,
    input  logic                                i_zero,
    output logic [rv_pkg::REG_ADDR_WIDTH - 1:0] o_rs1,
    output logic [rv_pkg::REG_ADDR_WIDTH - 1:0] o_rs2,
    output logic [rv_pkg::REG_ADDR_WIDTH - 1:0] o_rd,
    output logic [rv_pkg::XLEN - 1:0]           o_imm,
    output logic [MEM_ADDR_WIDTH - 1:0]         o_old_pc,
    output rv_pkg::alu_op_e                     o_alu_op,
    output logic [1:0]                          o_src_a_sel,
    output logic [1:0]                          o_src_b_sel,
    output logic [1:0]                          o_result_sel,
    output logic                                o_addr_sel,
    output logic                                o_pc_write,
    output logic                                o_reg_write,
    output logic                                o_mem_we
);
    import rv_pkg::*;

    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_ALU_WB, S_MEM_ADDR,
        S_MEM_READ, S_MEM_WB, S_MEM_WRITE, S_BRANCH, S_JUMP
    } state_e;

    state_e                   state;
    state_e                   state_next;
    logic [INSTR_WIDTH - 1:0] instr;
    opcode_e                  opcode;
    logic [2:0]               funct3;
    alu_op_e                  alu_funct;
    logic                     branch_taken;

    // ------------------------------------------------------------
    // Instruction and old-PC registers.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == S_FETCH) begin
            // Odd word of the doubleword when PC bit 2 is set.
            instr    <= i_pc[2] ? i_mem_rdata[63:32] : i_mem_rdata[31:0];
            o_old_pc <= i_pc;
        end
    end

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign o_rs1  = instr[19:15];
    assign o_rs2  = instr[24:20];
    assign o_rd   = instr[11:7];

    // Immediate generation.
    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD: o_imm = {{(XLEN - 12){instr[31]}}, instr[31:20]};
            OP_STORE:        o_imm = {{(XLEN - 12){instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH:       o_imm = {{(XLEN - 13){instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            OP_JAL:          o_imm = {{(XLEN - 21){instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
            default:         o_imm = '0;
        endcase
    end

    // ALU operation from funct3; funct7 bit 5 picks sub for R-type only.
    always_comb begin
        case (funct3)
            3'b000:  alu_funct = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_funct = ALU_SLT;
            3'b011:  alu_funct = ALU_SLTU;
            3'b100:  alu_funct = ALU_XOR;
            3'b110:  alu_funct = ALU_OR;
            3'b111:  alu_funct = ALU_AND;
            default: alu_funct = ALU_ADD;
        endcase
    end

    // beq on zero, bne on non-zero.
    assign branch_taken = (funct3 == 3'b000 && i_zero) || (funct3 == 3'b001 && !i_zero);

    // ------------------------------------------------------------
    // Control FSM.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next   = S_FETCH;
        o_alu_op     = ALU_ADD;
        o_src_a_sel  = SRC_A_PC;
        o_src_b_sel  = SRC_B_FOUR;
        o_result_sel = RES_ALU;
        o_addr_sel   = 1'b0;
        o_pc_write   = 1'b0;
        o_reg_write  = 1'b0;
        o_mem_we     = 1'b0;
        case (state)
            S_FETCH: begin
                o_pc_write = 1'b1;
                state_next = S_DECODE;
            end
            S_DECODE: begin
                // Branch or jump target into ALU-out.
                o_src_a_sel = SRC_A_OLD_PC;
                o_src_b_sel = SRC_B_IMM;
                case (opcode)
                    OP_REG, OP_IMM:    state_next = S_EXECUTE;
                    OP_LOAD, OP_STORE: state_next = S_MEM_ADDR;
                    OP_BRANCH:         state_next = S_BRANCH;
                    OP_JAL:            state_next = S_JUMP;
                    default:           state_next = S_FETCH;
                endcase
            end
            S_EXECUTE: begin
                o_src_a_sel = SRC_A_RS1;
                o_src_b_sel = (opcode == OP_REG) ? SRC_B_RS2 : SRC_B_IMM;
                o_alu_op    = alu_funct;
                state_next  = S_ALU_WB;
            end
            S_ALU_WB: begin
                o_result_sel = RES_ALU_OUT;
                o_reg_write  = 1'b1;
            end
            S_MEM_ADDR: begin
                o_src_a_sel = SRC_A_RS1;
                o_src_b_sel = SRC_B_IMM;
                state_next  = (opcode == OP_LOAD) ? S_MEM_READ : S_MEM_WRITE;
            end
            S_MEM_READ: begin
                o_result_sel = RES_ALU_OUT;
                o_addr_sel   = 1'b1;
                state_next   = S_MEM_WB;
            end
            S_MEM_WB: begin
                o_result_sel = RES_MEM_DATA;
                o_reg_write  = 1'b1;
            end
            S_MEM_WRITE: begin
                o_result_sel = RES_ALU_OUT;
                o_addr_sel   = 1'b1;
                o_mem_we     = 1'b1;
            end
            S_BRANCH: begin
                o_src_a_sel  = SRC_A_RS1;
                o_src_b_sel  = SRC_B_RS2;
                o_alu_op     = ALU_SUB;
                o_result_sel = RES_ALU_OUT;
                o_pc_write   = branch_taken;
            end
            S_JUMP: begin
                // Link value old_pc+4 lands in ALU-out for the write back.
                o_src_a_sel  = SRC_A_OLD_PC;
                o_result_sel = RES_ALU_OUT;
                o_pc_write   = 1'b1;
                state_next   = S_ALU_WB;
            end
            default: state_next = S_FETCH;
        endcase
    end

endmodule

/* execute/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic [rv_pkg::REG_ADDR_WIDTH - 1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_WIDTH - 1:0] i_rs2,
    input  logic [rv_pkg::REG_ADDR_WIDTH - 1:0] i_rd,
    input  logic                                i_reg_write,
    input  logic [rv_pkg::XLEN - 1:0]           i_result,
    input  logic [rv_pkg::XLEN - 1:0]           i_pc,
    input  logic [rv_pkg::XLEN - 1:0]           i_old_pc,
    input  logic [rv_pkg::XLEN - 1:0]           i_imm,
    input  logic [1:0]                          i_src_a_sel,
    input  logic [1:0]                          i_src_b_sel,
    input  rv_pkg::alu_op_e                     i_alu_op,
    output logic [rv_pkg::XLEN - 1:0]           o_alu_result,
    output logic                                o_zero,
    output logic [rv_pkg::XLEN - 1:0]           o_wdata
);
    import rv_pkg::*;

    logic [XLEN - 1:0] regs [1:31];
    logic [XLEN - 1:0] rd_data_1;
    logic [XLEN - 1:0] rd_data_2;
    logic [XLEN - 1:0] latch_a;
    logic [XLEN - 1:0] latch_b;
    logic [XLEN - 1:0] src_a;
    logic [XLEN - 1:0] src_b;

    // ------------------------------------------------------------
    // Register file.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reg_write && i_rd != '0) begin
            regs[i_rd] <= i_result;
        end
    end

    // x0 reads as zero.
    assign rd_data_1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign rd_data_2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

    // Operand latches, refreshed every cycle.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            latch_a <= '0;
            latch_b <= '0;
        end else begin
            latch_a <= rd_data_1;
            latch_b <= rd_data_2;
        end
    end

    assign o_wdata = latch_b;

    // ------------------------------------------------------------
    // Source multiplexers.
    // ------------------------------------------------------------
    always_comb begin
        case (i_src_a_sel)
            SRC_A_OLD_PC: src_a = i_old_pc;
            SRC_A_RS1:    src_a = latch_a;
            default:      src_a = i_pc;
        endcase
        case (i_src_b_sel)
            SRC_B_IMM:  src_b = i_imm;
            SRC_B_FOUR: src_b = XLEN'(4);
            default:    src_b = latch_b;
        endcase
    end

    // ALU.
    always_comb begin
        case (i_alu_op)
            ALU_SUB:  o_alu_result = src_a - src_b;
            ALU_AND:  o_alu_result = src_a & src_b;
            ALU_OR:   o_alu_result = src_a | src_b;
            ALU_XOR:  o_alu_result = src_a ^ src_b;
            ALU_SLT:  o_alu_result = {{(XLEN - 1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: o_alu_result = {{(XLEN - 1){1'b0}}, src_a < src_b};
            default:  o_alu_result = src_a + src_b;
        endcase
    end

    assign o_zero = (o_alu_result == '0);

endmodule

/* writeback/rv_writeback.sv */
`timescale 1ns/1ps

module rv_writeback #(
    parameter int MEM_ADDR_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic [rv_pkg::XLEN - 1:0]   i_alu_result,
    input  logic [rv_pkg::XLEN - 1:0]   i_mem_rdata,
    input  logic [1:0]                  i_result_sel,
    input  logic                        i_addr_sel,
    input  logic                        i_pc_write,
    output logic [rv_pkg::XLEN - 1:0]   o_result,
    output logic [MEM_ADDR_WIDTH - 1:0] o_pc,
    output logic [MEM_ADDR_WIDTH - 1:0] o_mem_addr
);
    import rv_pkg::*;

    logic [XLEN - 1:0] alu_out;
    logic [XLEN - 1:0] mem_data;

    // ------------------------------------------------------------
    // Holding registers, loaded every cycle.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        alu_out  <= i_alu_result;
        mem_data <= i_mem_rdata;
    end

    // Result multiplexer.
    always_comb begin
        case (i_result_sel)
            RES_MEM_DATA: o_result = mem_data;
            RES_ALU:      o_result = i_alu_result;
            default:      o_result = alu_out;
        endcase
    end

    // Program counter.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc <= '0;
        end else if (i_pc_write) begin
            o_pc <= o_result[MEM_ADDR_WIDTH - 1:0];
        end
    end

    // PC on fetch, computed address for loads and stores.
    assign o_mem_addr = i_addr_sel ? o_result[MEM_ADDR_WIDTH - 1:0] : o_pc;

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter int MEM_ADDR_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        i_reset,
    output logic [MEM_ADDR_WIDTH - 1:0] o_mem_addr,
    output logic [rv_pkg::XLEN - 1:0]   o_mem_wdata,
    output logic                        o_mem_we,
    input  logic [rv_pkg::XLEN - 1:0]   i_mem_rdata
);
    import rv_pkg::*;

    // ------------------------------------------------------------
    // Internal nets.
    // ------------------------------------------------------------

    // Control from decode.
    alu_op_e                     alu_op;
    logic [1:0]                  src_a_sel;
    logic [1:0]                  src_b_sel;
    logic [1:0]                  result_sel;
    logic                        addr_sel;
    logic                        pc_write;
    logic                        reg_write;

    // Instruction fields.
    logic [REG_ADDR_WIDTH - 1:0] rs1;
    logic [REG_ADDR_WIDTH - 1:0] rs2;
    logic [REG_ADDR_WIDTH - 1:0] rd;
    logic [XLEN - 1:0]           imm;
    logic [MEM_ADDR_WIDTH - 1:0] old_pc;

    // Datapath.
    logic [XLEN - 1:0]           alu_result;
    logic                        zero;
    logic [XLEN - 1:0]           result;
    logic [MEM_ADDR_WIDTH - 1:0] pc;

    // ------------------------------------------------------------
    // Instances.
    // ------------------------------------------------------------
    rv_decode #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_decode (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_mem_rdata  (i_mem_rdata),
        .i_pc         (pc),
        .i_zero       (zero),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_rd         (rd),
        .o_imm        (imm),
        .o_old_pc     (old_pc),
        .o_alu_op     (alu_op),
        .o_src_a_sel  (src_a_sel),
        .o_src_b_sel  (src_b_sel),
        .o_result_sel (result_sel),
        .o_addr_sel   (addr_sel),
        .o_pc_write   (pc_write),
        .o_reg_write  (reg_write),
        .o_mem_we     (o_mem_we)
    );

    // PC values are zero extended to the datapath width.
    rv_execute u_execute (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .i_rd         (rd),
        .i_reg_write  (reg_write),
        .i_result     (result),
        .i_pc         ({{(XLEN - MEM_ADDR_WIDTH){1'b0}}, pc}),
        .i_old_pc     ({{(XLEN - MEM_ADDR_WIDTH){1'b0}}, old_pc}),
        .i_imm        (imm),
        .i_src_a_sel  (src_a_sel),
        .i_src_b_sel  (src_b_sel),
        .i_alu_op     (alu_op),
        .o_alu_result (alu_result),
        .o_zero       (zero),
        .o_wdata      (o_mem_wdata)
    );

    rv_writeback #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_writeback (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_alu_result (alu_result),
        .i_mem_rdata  (i_mem_rdata),
        .i_result_sel (result_sel),
        .i_addr_sel   (addr_sel),
        .i_pc_write   (pc_write),
        .o_result     (result),
        .o_pc         (pc),
        .o_mem_addr   (o_mem_addr)
    );

endmodule

/* tests/rv_core_chk.sv */
`timescale 1ns/1ps

module rv_core_chk #(
    parameter int MEM_ADDR_WIDTH = 16
) (
    input logic                        clk,
    input logic                        i_reset,
    input logic                        i_mem_we,
    input logic [MEM_ADDR_WIDTH - 1:0] i_mem_addr
);

    // Number of failed assertions.
    int assert_errors = 0;

    // ------------------------------------------------------------
    // Memory strobe.
    // ------------------------------------------------------------
    no_store_in_reset: assert property (@(posedge clk) $past(i_reset) && i_reset |-> !i_mem_we)
        else begin
            $error("memory write strobe high during reset");
            assert_errors++;
        end

    // A store holds the strobe for exactly one cycle.
    single_cycle_store: assert property (@(posedge clk) disable iff (i_reset)
        i_mem_we |=> !i_mem_we)
        else begin
            $error("memory write strobe high on two cycles in a row");
            assert_errors++;
        end

    // ------------------------------------------------------------
    // Addresses.
    // ------------------------------------------------------------
    aligned_store: assert property (@(posedge clk) disable iff (i_reset)
        i_mem_we |-> i_mem_addr[2:0] == 3'b000)
        else begin
            $error("store address not doubleword aligned");
            assert_errors++;
        end

endmodule

/* tests/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int MEM_ADDR_WIDTH = 16;
    localparam int DEPTH          = 1 << (MEM_ADDR_WIDTH - 3);
    localparam logic [31:0] HALT  = 32'h0000_0063;  // beq x0, x0, 0

    logic                        clk;
    logic                        i_reset;
    logic [MEM_ADDR_WIDTH - 1:0] mem_addr;
    logic [XLEN - 1:0]           mem_wdata;
    logic                        mem_we;
    logic [XLEN - 1:0]           mem_rdata;

    logic [XLEN - 1:0]           image   [0:DEPTH - 1];
    logic [XLEN - 1:0]           mem     [0:DEPTH - 1];
    logic [XLEN - 1:0]           ref_mem [0:DEPTH - 1];
    logic [MEM_ADDR_WIDTH - 1:0] exp_addr [$];
    logic [XLEN - 1:0]           exp_data [$];
    logic [MEM_ADDR_WIDTH - 1:0] build_pc;
    logic [MEM_ADDR_WIDTH - 1:0] want_addr;
    logic [XLEN - 1:0]           want_data;
    logic [XLEN - 1:0]           val_a;
    logic [XLEN - 1:0]           val_b;
    string                       test_name;
    int                          errors;
    int                          test_errors;
    int                          tests;
    int                          failed;
    int                          stores_seen;

    rv_core #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) i_rv_core (
        .clk         (clk),
        .i_reset     (i_reset),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_we    (mem_we),
        .i_mem_rdata (mem_rdata)
    );

    bind rv_core rv_core_chk #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_chk (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_mem_we   (o_mem_we),
        .i_mem_addr (o_mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Memory model with a combinational read.
    // ------------------------------------------------------------
    assign mem_rdata = mem[mem_addr[MEM_ADDR_WIDTH - 1:3]];

    always @(posedge clk) begin
        if (mem_we === 1'b1) begin
            mem[mem_addr[MEM_ADDR_WIDTH - 1:3]] <= mem_wdata;
        end
    end

    // ------------------------------------------------------------
    // Instruction encoders.
    // ------------------------------------------------------------
    function automatic logic [31:0] rtype(input logic [2:0] f3, input logic f7_5,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, f7_5, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Always sd.
    function automatic logic [31:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // ------------------------------------------------------------
    // Program builder.
    // ------------------------------------------------------------
    task automatic clear_image();
        for (int i = 0; i < DEPTH; i++) begin
            image[i] = {32'(i) * 32'h9e37_79b9, 32'h5a5a_0000 ^ 32'(i)};
        end
        build_pc = '0;
    endtask

    task automatic emit(input logic [31:0] word);
        if (build_pc[2]) begin
            image[build_pc[MEM_ADDR_WIDTH - 1:3]][63:32] = word;
        end else begin
            image[build_pc[MEM_ADDR_WIDTH - 1:3]][31:0] = word;
        end
        build_pc += 4;
    endtask

    task automatic put_data(input logic [MEM_ADDR_WIDTH - 1:0] addr, input logic [XLEN - 1:0] d);
        image[addr[MEM_ADDR_WIDTH - 1:3]] = d;
    endtask

    // ------------------------------------------------------------
    // Reference interpreter.
    // ------------------------------------------------------------
    function automatic logic [XLEN - 1:0] alu_model(input logic [2:0] f3, input logic sub,
                                                    input logic [XLEN - 1:0] a,
                                                    input logic [XLEN - 1:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // Runs the image until the self-branch and queues every store.
    function automatic void ref_run();
        logic [XLEN - 1:0]           x [0:31];
        logic [XLEN - 1:0]           a;
        logic [XLEN - 1:0]           b;
        logic [XLEN - 1:0]           imm_i;
        logic [XLEN - 1:0]           ea;
        logic [31:0]                 w;
        logic [MEM_ADDR_WIDTH - 1:0] pc;
        logic [MEM_ADDR_WIDTH - 1:0] next_pc;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        ref_mem = image;
        exp_addr.delete();
        exp_data.delete();
        pc = '0;
        for (int step = 0; step < 4000; step++) begin
            w = pc[2] ? ref_mem[pc[MEM_ADDR_WIDTH - 1:3]][63:32]
                      : ref_mem[pc[MEM_ADDR_WIDTH - 1:3]][31:0];
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm_i = {{52{w[31]}}, w[31:20]};
            next_pc = pc + 4;
            case (w[6:0])
                OP_REG: x[w[11:7]] = alu_model(w[14:12], w[30], a, b);
                OP_IMM: x[w[11:7]] = alu_model(w[14:12], 1'b0, a, imm_i);
                OP_LOAD: begin
                    ea = a + imm_i;
                    x[w[11:7]] = ref_mem[ea[MEM_ADDR_WIDTH - 1:3]];
                end
                OP_STORE: begin
                    ea = a + {{52{w[31]}}, w[31:25], w[11:7]};
                    ref_mem[ea[MEM_ADDR_WIDTH - 1:3]] = b;
                    exp_addr.push_back(ea[MEM_ADDR_WIDTH - 1:0]);
                    exp_data.push_back(b);
                end
                OP_BRANCH: begin
                    ea = {{(XLEN - MEM_ADDR_WIDTH){1'b0}}, pc}
                         + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
                        next_pc = ea[MEM_ADDR_WIDTH - 1:0];
                    end
                end
                OP_JAL: begin
                    x[w[11:7]] = {{(XLEN - MEM_ADDR_WIDTH){1'b0}}, pc} + 4;
                    ea = {{(XLEN - MEM_ADDR_WIDTH){1'b0}}, pc}
                         + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                    next_pc = ea[MEM_ADDR_WIDTH - 1:0];
                end
                default: ;
            endcase
            x[0] = '0;
            if (next_pc == pc) begin
                break;
            end
            pc = next_pc;
        end
    endfunction

    // ------------------------------------------------------------
    // Store comparison.
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (mem_we === 1'b1) begin
            stores_seen++;
            if (exp_addr.size() == 0) begin
                $display("%s: unexpected store to address %h", test_name, mem_addr);
                test_errors++;
            end else begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                if (mem_addr !== want_addr) begin
                    $display("error %s store address expected %h actual %h",
                             test_name, want_addr, mem_addr);
                    test_errors++;
                end
                if (mem_wdata !== want_data) begin
                    $display("error %s store data expected %h actual %h",
                             test_name, want_data, mem_wdata);
                    test_errors++;
                end
            end
        end
    end

    // Reset spans three rising edges and is released on a falling edge.
    task automatic apply_reset();
        i_reset = 1'b1;
        mem = image;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (mem_addr !== '0) begin
            $display("error %s fetch address expected %h actual %h", test_name, 16'h0, mem_addr);
            test_errors++;
        end
        i_reset = 1'b0;
    endtask

    task automatic run_program(input string name);
        int idle;
        int left;
        test_name = name;
        test_errors = 0;
        ref_run();
        apply_reset();
        idle = 0;
        left = exp_addr.size();
        while (exp_addr.size() != 0 && idle < 2000) begin
            @(negedge clk);
            idle = (exp_addr.size() == left) ? idle + 1 : 0;
            left = exp_addr.size();
        end
        if (exp_addr.size() != 0) begin
            $display("%s: no store arrived within 2000 cycles, %0d stores missing",
                     name, exp_addr.size());
            test_errors++;
        end
        // Core sits in the halt loop. Any further store is stray.
        idle = 0;
        while (idle < 40) begin
            @(negedge clk);
            idle++;
        end
        @(posedge clk);
        tests++;
        errors += test_errors;
        if (test_errors != 0) begin
            failed++;
        end
        $display("test %s done, %0d errors", name, test_errors);
        exp_addr.delete();
        exp_data.delete();
        @(negedge clk);
    endtask

    initial begin
        i_reset = 1'b1;
        errors = 0;
        tests = 0;
        failed = 0;
        stores_seen = 0;
        test_errors = 0;
        void'($urandom(58));

        clear_image();
        emit(itype(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
        emit(itype(OP_IMM, 3'b000, 5'd2, 5'd1, 12'h7ff));
        emit(stype(5'd1, 5'd0, 12'h600));
        emit(stype(5'd2, 5'd0, 12'h608));
        emit(HALT);
        run_program("reset_fetch");

        // Negative and positive operands for the compares.
        clear_image();
        val_a = {1'b1, 31'($urandom), 32'($urandom)};
        val_b = {1'b0, 31'($urandom), 32'($urandom)};
        put_data(16'h400, val_a);
        put_data(16'h408, val_b);
        emit(itype(OP_LOAD, 3'b011, 5'd1, 5'd0, 12'h400));
        emit(itype(OP_LOAD, 3'b011, 5'd2, 5'd0, 12'h408));
        emit(rtype(3'b000, 1'b0, 5'd3, 5'd1, 5'd2));
        emit(rtype(3'b000, 1'b1, 5'd4, 5'd1, 5'd2));
        emit(rtype(3'b111, 1'b0, 5'd5, 5'd1, 5'd2));
        emit(rtype(3'b110, 1'b0, 5'd6, 5'd1, 5'd2));
        emit(rtype(3'b100, 1'b0, 5'd7, 5'd1, 5'd2));
        emit(rtype(3'b010, 1'b0, 5'd8, 5'd1, 5'd2));
        emit(rtype(3'b011, 1'b0, 5'd9, 5'd1, 5'd2));
        emit(rtype(3'b010, 1'b0, 5'd10, 5'd2, 5'd1));
        emit(rtype(3'b011, 1'b0, 5'd11, 5'd2, 5'd1));
        for (int r = 3; r <= 11; r++) begin
            emit(stype(5'(r), 5'd0, 12'(12'h600 + 8 * r)));
        end
        emit(HALT);
        run_program("r_type");

        clear_image();
        put_data(16'h400, {32'($urandom), 32'($urandom)});
        emit(itype(OP_LOAD, 3'b011, 5'd1, 5'd0, 12'h400));
        emit(itype(OP_IMM, 3'b000, 5'd2, 5'd1, 12'($urandom) | 12'h800));
        emit(itype(OP_IMM, 3'b111, 5'd3, 5'd1, 12'($urandom)));
        emit(itype(OP_IMM, 3'b110, 5'd4, 5'd1, 12'($urandom) | 12'h800));
        emit(itype(OP_IMM, 3'b100, 5'd5, 5'd1, 12'($urandom)));
        emit(itype(OP_IMM, 3'b010, 5'd6, 5'd1, 12'($urandom)));
        emit(itype(OP_IMM, 3'b010, 5'd7, 5'd0, 12'($urandom) | 12'h800));
        for (int r = 2; r <= 7; r++) begin
            emit(stype(5'(r), 5'd0, 12'(12'h600 + 8 * r)));
        end
        emit(HALT);
        run_program("i_type");

        clear_image();
        put_data(16'h400, {32'($urandom), 32'($urandom)});
        put_data(16'h408, {32'($urandom), 32'($urandom)});
        emit(itype(OP_LOAD, 3'b011, 5'd1, 5'd0, 12'h400));
        emit(itype(OP_LOAD, 3'b011, 5'd2, 5'd0, 12'h408));
        emit(stype(5'd1, 5'd0, 12'h700));
        emit(stype(5'd2, 5'd0, 12'h718));
        emit(itype(OP_LOAD, 3'b011, 5'd3, 5'd0, 12'h718));
        emit(itype(OP_LOAD, 3'b011, 5'd4, 5'd0, 12'h700));
        emit(stype(5'd3, 5'd0, 12'h610));
        emit(stype(5'd4, 5'd0, 12'h620));
        emit(HALT);
        run_program("load_store");

        // Taken branches and the jal skip the store right after them.
        clear_image();
        emit(itype(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd3));
        emit(itype(OP_IMM, 3'b000, 5'd2, 5'd0, 12'd3));
        emit(itype(OP_IMM, 3'b000, 5'd3, 5'd0, 12'd4));
        emit(btype(3'b000, 5'd1, 5'd2, 13'd8));
        emit(stype(5'd1, 5'd0, 12'h600));
        emit(btype(3'b001, 5'd1, 5'd3, 13'd8));
        emit(stype(5'd2, 5'd0, 12'h608));
        emit(btype(3'b000, 5'd1, 5'd3, 13'd8));
        emit(stype(5'd3, 5'd0, 12'h610));
        emit(btype(3'b001, 5'd1, 5'd2, 13'd8));
        emit(stype(5'd2, 5'd0, 12'h618));
        emit(jtype(5'd5, 21'd8));
        emit(stype(5'd1, 5'd0, 12'h620));
        emit(stype(5'd5, 5'd0, 12'h628));
        emit(HALT);
        run_program("control_flow");

        clear_image();
        put_data(16'h400, {32'($urandom), 32'($urandom)});
        emit(itype(OP_IMM, 3'b000, 5'd0, 5'd0, 12'd123));
        emit(itype(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd9));
        emit(rtype(3'b000, 1'b0, 5'd0, 5'd1, 5'd1));
        emit(itype(OP_LOAD, 3'b011, 5'd0, 5'd0, 12'h400));
        emit(32'habcd_e0b7);  // lui x1 is not in the subset.
        emit(stype(5'd0, 5'd0, 12'h600));
        emit(stype(5'd1, 5'd0, 12'h608));
        emit(HALT);
        run_program("x0_and_skip");

        errors += i_rv_core.u_chk.assert_errors;
        $display("%0d tests, %0d failed, %0d stores seen, %0d assertion failures, %0d errors",
                 tests, failed, stores_seen, i_rv_core.u_chk.assert_errors, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/rv_pkg.sv
decode/rv_decode.sv
execute/rv_execute.sv
writeback/rv_writeback.sv
design/rv_core.sv
tests/rv_core_chk.sv
tests/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - decode/rv_decode.sv
  - execute/rv_execute.sv
  - writeback/rv_writeback.sv
  - design/rv_core.sv
  - target: test
    files:
      - tests/rv_core_chk.sv
      - tests/tb_rv_core.sv
